/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = alu_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/alu_input.txt */
# op operand_a operand_b imm expected_result expected_branch, all hex
# op codes follow alu_op_e in src/alu_pkg.sv
00 0000000000000005 0000000000000003 0000000000000000 0000000000000008 1
00 FFFFFFFFFFFFFFFF 0000000000000002 0000000000000000 0000000000000001 1
01 0000000000000003 0000000000000005 0000000000000000 FFFFFFFFFFFFFFFE 1
02 000000007FFFFFFF 0000000000000001 0000000000000000 FFFFFFFF80000000 1
03 1234567800000000 0000000000000001 0000000000000000 FFFFFFFFFFFFFFFF 1
04 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 0000000000000000 F000F000F000F000 1
05 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 0000000000000000 FFF0FFF0FFF0FFF0 1
06 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 0000000000000000 0FF00FF00FF00FF0 1
07 0000000000000001 000000000000003F 0000000000000000 8000000000000000 1
07 0000000000000003 0000000000000044 0000000000000000 0000000000000030 1
08 8000000000000000 0000000000000004 0000000000000000 0800000000000000 1
09 8000000000000000 0000000000000004 0000000000000000 F800000000000000 1
0A 0000000000000001 000000000000001F 0000000000000000 FFFFFFFF80000000 1
0B FFFFFFFF80000000 0000000000000024 0000000000000000 0000000008000000 1
0C 0000000080000000 0000000000000004 0000000000000000 FFFFFFFFF8000000 1
0D FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 0000000000000001 1
0E FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 0000000000000000 1
0F 0000000000000007 0000000000000007 0000000000000000 0000000000000000 1
10 0000000000000007 0000000000000007 0000000000000000 0000000000000000 0
11 FFFFFFFFFFFFFFFE 0000000000000001 0000000000000000 FFFFFFFFFFFFFFFF 1
12 FFFFFFFFFFFFFFFE 0000000000000001 0000000000000000 FFFFFFFFFFFFFFFF 0
13 FFFFFFFFFFFFFFFE 0000000000000001 0000000000000000 FFFFFFFFFFFFFFFF 0
14 FFFFFFFFFFFFFFFE 0000000000000001 0000000000000000 FFFFFFFFFFFFFFFF 1
0F 0000000000000005 0000000000000003 0000000000000000 0000000000000002 0
15 20307F01F0108005 20100102F010FF3A 0000000000000000 3F3F3F03E0207F3F 1
16 501000807F400520 102001018000FBE0 0000000000000000 3FF0FF7F3F3F0A3F 1
17 200110F07F000508 300110F001000508 10FF058040000A01 100205803F000A01 1
18 904523F012773081 00000000000000FF 0000000000000000 0000000000000012 1
18 904523F012773081 0000000000000005 0000000000000000 0000000000000005 1
18 FFFFFFFFFFFFFF80 00000000000000C0 0000000000000000 0000000000000080 1
09 FFFFFFFF00000000 0000000000000060 0000000000000000 FFFFFFFFFFFFFFFF 1
08 123456789ABCDEF0 0000000000000040 0000000000000000 123456789ABCDEF0 1
09 4000000000000000 000000000000003E 0000000000000000 0000000000000001 1
03 0000000100000005 0000000000000002 0000000000000000 0000000000000003 1

/* bench/alu_tb.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_tb import alu_pkg::*; ();

    localparam string VEC_FILE = "bench/alu_input.txt";

    logic                 clk_i;
    logic                 rst_i;
    logic                 valid_i;
    alu_op_e              op_i;
    logic [`ALU_XLEN-1:0] operand_a_i;
    logic [`ALU_XLEN-1:0] operand_b_i;
    logic [`ALU_XLEN-1:0] imm_i;
    logic                 valid_o;
    logic [`ALU_XLEN-1:0] result_o;
    logic                 branch_res_o;

    // Vectors as read from the data file
    logic [4:0]           vec_op [$];
    logic [`ALU_XLEN-1:0] vec_a [$];
    logic [`ALU_XLEN-1:0] vec_b [$];
    logic [`ALU_XLEN-1:0] vec_imm [$];
    logic [`ALU_XLEN-1:0] vec_res [$];
    logic                 vec_br [$];

    // Operations issued and still waiting for their result
    logic [4:0]           exp_op_q [$];
    logic [`ALU_XLEN-1:0] exp_res_q [$];
    logic                 exp_br_q [$];

    logic                 prev_valid;
    logic [`ALU_XLEN-1:0] last_result;
    logic                 last_branch;
    int                   value_errors = 0;
    int                   other_errors = 0;
    int                   cycle_count = 0;
    int                   cycle_limit = 50;

    alu_top DUT (
        .clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .op_i(op_i),
        .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .imm_i(imm_i),
        .valid_o(valid_o), .result_o(result_o), .branch_res_o(branch_res_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d wrong values, %0d other failures", value_errors,
                     other_errors);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Vector file
    // --------------------------------------------------
    task automatic load_vectors();
        int                   fd;
        int                   fields;
        string                line;
        logic [4:0]           op;
        logic [`ALU_XLEN-1:0] a, b, imm, res;
        logic [3:0]           br;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                // Comment lines fail the hex parse and are skipped
                fields = $sscanf(line, "%h %h %h %h %h %h", op, a, b, imm, res, br);
                if (fields == 6) begin
                    vec_op.push_back(op);
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    vec_imm.push_back(imm);
                    vec_res.push_back(res);
                    vec_br.push_back(br[0]);
                end
            end
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // Drive and check
    // --------------------------------------------------
    task automatic drive_vector(input int idx);
        valid_i     = 1'b1;
        op_i        = alu_op_e'(vec_op[idx]);
        operand_a_i = vec_a[idx];
        operand_b_i = vec_b[idx];
        imm_i       = vec_imm[idx];
        exp_op_q.push_back(vec_op[idx]);
        exp_res_q.push_back(vec_res[idx]);
        exp_br_q.push_back(vec_br[idx]);
        prev_valid = 1'b1;
    endtask

    // Idle data would change the result if it were loaded
    task automatic drive_idle();
        valid_i     = 1'b0;
        op_i        = OP_ADD;
        operand_a_i = '1;
        operand_b_i = '1;
        imm_i       = '0;
        prev_valid  = 1'b0;
    endtask

    // Called at a falling edge, outputs settled since the last rising edge
    task automatic check_outputs();
        logic [4:0]           op;
        logic [`ALU_XLEN-1:0] exp_res;
        logic                 exp_br;
        assert (valid_o == prev_valid) else begin
            $display("ERROR at %0t: valid_o is %0b, expected %0b", $time, valid_o,
                     prev_valid);
            value_errors++;
        end
        if (prev_valid) begin
            op      = exp_op_q.pop_front();
            exp_res = exp_res_q.pop_front();
            exp_br  = exp_br_q.pop_front();
            assert (result_o == exp_res) else begin
                $display("ERROR at %0t: op %0d result %h, expected %h", $time, op,
                         result_o, exp_res);
                value_errors++;
            end
            assert (branch_res_o == exp_br) else begin
                $display("ERROR at %0t: op %0d branch %0b, expected %0b", $time, op,
                         branch_res_o, exp_br);
                value_errors++;
            end
            last_result = exp_res;
            last_branch = exp_br;
        end else begin
            assert (result_o == last_result && branch_res_o == last_branch) else begin
                $display("ERROR at %0t: idle output %h/%0b, expected held %h/%0b", $time,
                         result_o, branch_res_o, last_result, last_branch);
                value_errors++;
            end
        end
    endtask

    task automatic check_reset_state();
        assert (valid_o == 1'b0 && result_o == '0 && branch_res_o == 1'b1) else begin
            $display("ERROR at %0t: reset state %0b/%h/%0b, expected 0/0/1", $time,
                     valid_o, result_o, branch_res_o);
            value_errors++;
        end
    endtask

    initial begin
        rst_i       = 1'b1;
        prev_valid  = 1'b0;
        last_result = '0;
        last_branch = 1'b1;
        drive_idle();
        load_vectors();
        cycle_limit = 2 * vec_op.size() + 50;
        if (vec_op.size() == 0 && other_errors == 0) begin
            $display("The vector file holds no test vectors");
            other_errors++;
        end

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        check_reset_state();

        for (int i = 0; i < vec_op.size(); i++) begin
            @(negedge clk_i);
            check_outputs();
            drive_vector(i);
            // Two idle slots after each group of eight
            if (i % 8 == 7) begin
                repeat (2) begin
                    @(negedge clk_i);
                    check_outputs();
                    drive_idle();
                end
            end
        end

        repeat (3) begin
            @(negedge clk_i);
            check_outputs();
            drive_idle();
        end
        if (exp_res_q.size() != 0) begin
            $display("Some operations never produced a result");
            other_errors++;
        end

        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* include/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Datapath widths
`define ALU_XLEN    64
`define ALU_WORD    32

// SIMD lane layout for the polar decoder ops
`define ALU_LANES   8
`define ALU_LANE_W  8

// Upper clamp applied to each saturating lane
`define ALU_SAT_MAX 63

`endif

/* list.f */
+incdir+include
src/alu_pkg.sv
src/alu_decode.sv
src/alu_adder.sv
src/alu_shifter.sv
src/alu_polar_simd.sv
src/alu_result.sv
src/alu_top.sv
bench/alu_tb.sv

/* src/alu_adder.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_adder import alu_pkg::*; (
    input  logic [`ALU_XLEN-1:0] operand_a_i,
    input  logic [`ALU_XLEN-1:0] operand_b_i,
    input  logic                 negate_b_i,
    input  logic                 signed_cmp_i,
    input  br_sel_e              br_sel_i,
    output logic [`ALU_XLEN-1:0] sum_o,
    output logic                 less_o,
    output logic                 branch_res_o
);

    logic [`ALU_XLEN:0] adder_in_a;
    logic [`ALU_XLEN:0] adder_in_b;
    logic [`ALU_XLEN:0] adder_ext;
    logic               zero_flag;

    // --------------------------------------------------
    // Adder
    // --------------------------------------------------

    // Extra low bit carries the +1 of the two's complement
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i, 1'b0} ^ {(`ALU_XLEN+1){negate_b_i}};
    assign adder_ext  = adder_in_a + adder_in_b;
    assign sum_o      = adder_ext[`ALU_XLEN:1];
    assign zero_flag  = ~|sum_o;

    // --------------------------------------------------
    // Compare and branch
    // --------------------------------------------------

    assign less_o = $signed({signed_cmp_i & operand_a_i[`ALU_XLEN-1], operand_a_i}) <
                    $signed({signed_cmp_i & operand_b_i[`ALU_XLEN-1], operand_b_i});

    always_comb begin
        case (br_sel_i)
            BR_EQ:   branch_res_o = zero_flag;
            BR_NE:   branch_res_o = ~zero_flag;
            BR_LT:   branch_res_o = less_o;
            BR_GE:   branch_res_o = ~less_o;
            default: branch_res_o = 1'b1;
        endcase
    end

endmodule

/* src/alu_decode.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_decode import alu_pkg::*; (
    input  alu_op_e  op_i,
    output logic     negate_b_o,
    output logic     signed_cmp_o,
    output logic     shift_left_o,
    output logic     shift_arith_o,
    output res_sel_e res_sel_o,
    output br_sel_e  br_sel_o
);

    always_comb begin
        negate_b_o    = 1'b0;
        signed_cmp_o  = 1'b0;
        shift_left_o  = 1'b0;
        shift_arith_o = 1'b0;
        // Branches also fall through to the adder result
        res_sel_o     = RES_ADDER;
        br_sel_o      = BR_NONE;

        case (op_i)
            OP_ADD:  res_sel_o = RES_ADDER;
            OP_SUB: begin
                negate_b_o = 1'b1;
            end
            OP_ADDW: res_sel_o = RES_ADDER_W;
            OP_SUBW: begin
                negate_b_o = 1'b1;
                res_sel_o  = RES_ADDER_W;
            end
            OP_ANDL: res_sel_o = RES_AND;
            OP_ORL:  res_sel_o = RES_OR;
            OP_XORL: res_sel_o = RES_XOR;
            OP_SLL: begin
                shift_left_o = 1'b1;
                res_sel_o    = RES_SHIFT;
            end
            OP_SRL:  res_sel_o = RES_SHIFT;
            OP_SRA: begin
                shift_arith_o = 1'b1;
                res_sel_o     = RES_SHIFT;
            end
            OP_SLLW: begin
                shift_left_o = 1'b1;
                res_sel_o    = RES_SHIFT_W;
            end
            OP_SRLW: res_sel_o = RES_SHIFT_W;
            OP_SRAW: begin
                shift_arith_o = 1'b1;
                res_sel_o     = RES_SHIFT_W;
            end
            OP_SLTS: begin
                signed_cmp_o = 1'b1;
                res_sel_o    = RES_SLT;
            end
            OP_SLTU: res_sel_o = RES_SLT;
            // Equality works on the zero flag of a - b
            OP_EQ: begin
                negate_b_o = 1'b1;
                br_sel_o   = BR_EQ;
            end
            OP_NE: begin
                negate_b_o = 1'b1;
                br_sel_o   = BR_NE;
            end
            OP_LTS: begin
                signed_cmp_o = 1'b1;
                br_sel_o     = BR_LT;
            end
            OP_LTU:  br_sel_o = BR_LT;
            OP_GES: begin
                signed_cmp_o = 1'b1;
                br_sel_o     = BR_GE;
            end
            OP_GEU:  br_sel_o = BR_GE;
            OP_LDN_ADDUSAT:   res_sel_o = RES_SIMD_ADDSAT;
            OP_LDN_SUBUSAT:   res_sel_o = RES_SIMD_SUBSAT;
            OP_LDN_ADDSATMIN: res_sel_o = RES_SIMD_ADDSATMIN;
            OP_LDN_HMIN:      res_sel_o = RES_SIMD_HMIN;
            default: ;
        endcase
    end

endmodule

/* src/alu_pkg.sv */
package alu_pkg;

    // Operator codes, numeric values are fixed for the vector files
    typedef enum logic [4:0] {
        OP_ADD         = 5'd0,
        OP_SUB         = 5'd1,
        OP_ADDW        = 5'd2,
        OP_SUBW        = 5'd3,
        OP_ANDL        = 5'd4,
        OP_ORL         = 5'd5,
        OP_XORL        = 5'd6,
        OP_SLL         = 5'd7,
        OP_SRL         = 5'd8,
        OP_SRA         = 5'd9,
        OP_SLLW        = 5'd10,
        OP_SRLW        = 5'd11,
        OP_SRAW        = 5'd12,
        OP_SLTS        = 5'd13,
        OP_SLTU        = 5'd14,
        OP_EQ          = 5'd15,
        OP_NE          = 5'd16,
        OP_LTS         = 5'd17,
        OP_LTU         = 5'd18,
        OP_GES         = 5'd19,
        OP_GEU         = 5'd20,
        OP_LDN_ADDUSAT   = 5'd21,
        OP_LDN_SUBUSAT   = 5'd22,
        OP_LDN_ADDSATMIN = 5'd23,
        OP_LDN_HMIN      = 5'd24
    } alu_op_e;

    // Source of the registered result
    typedef enum logic [3:0] {
        RES_ADDER, RES_ADDER_W, RES_AND, RES_OR, RES_XOR, RES_SHIFT, RES_SHIFT_W,
        RES_SLT, RES_SIMD_ADDSAT, RES_SIMD_SUBSAT, RES_SIMD_ADDSATMIN, RES_SIMD_HMIN
    } res_sel_e;

    // Branch condition evaluated by the adder
    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} br_sel_e;

endpackage

/* src/alu_polar_simd.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_polar_simd (
    input  logic [`ALU_XLEN-1:0]   operand_a_i,
    input  logic [`ALU_XLEN-1:0]   operand_b_i,
    input  logic [`ALU_XLEN-1:0]   imm_i,
    output logic [`ALU_XLEN-1:0]   addsat_o,
    output logic [`ALU_XLEN-1:0]   subsat_o,
    output logic [`ALU_XLEN-1:0]   addsatmin_o,
    output logic [`ALU_LANE_W-1:0] hmin_o
);

    logic [`ALU_LANE_W-1:0] min_l1 [`ALU_LANES/2];
    logic [`ALU_LANE_W-1:0] min_l2 [`ALU_LANES/4];

    // --------------------------------------------------
    // Per-lane saturating arithmetic
    // --------------------------------------------------
    for (genvar i = 0; i < `ALU_LANES; i++) begin : gen_lane
        logic [`ALU_LANE_W-1:0] lane_a, lane_b, lane_imm;
        logic [`ALU_LANE_W:0]   lane_sum, lane_diff;
        logic [`ALU_LANE_W-1:0] sat_sum, sat_diff;

        assign lane_a   = operand_a_i[i*`ALU_LANE_W +: `ALU_LANE_W];
        assign lane_b   = operand_b_i[i*`ALU_LANE_W +: `ALU_LANE_W];
        assign lane_imm = imm_i[i*`ALU_LANE_W +: `ALU_LANE_W];

        // Nine bits hold the signed overflow
        assign lane_sum  = {lane_a[`ALU_LANE_W-1], lane_a} + {lane_b[`ALU_LANE_W-1], lane_b};
        assign lane_diff = {lane_a[`ALU_LANE_W-1], lane_a} - {lane_b[`ALU_LANE_W-1], lane_b};

        // Only the upper limit clamps, negatives wrap
        assign sat_sum  = ($signed(lane_sum) > `ALU_SAT_MAX) ?
                          `ALU_LANE_W'(`ALU_SAT_MAX) : lane_sum[`ALU_LANE_W-1:0];
        assign sat_diff = ($signed(lane_diff) > `ALU_SAT_MAX) ?
                          `ALU_LANE_W'(`ALU_SAT_MAX) : lane_diff[`ALU_LANE_W-1:0];

        assign addsat_o[i*`ALU_LANE_W +: `ALU_LANE_W]    = sat_sum;
        assign subsat_o[i*`ALU_LANE_W +: `ALU_LANE_W]    = sat_diff;
        assign addsatmin_o[i*`ALU_LANE_W +: `ALU_LANE_W] = (sat_sum > lane_imm) ?
                                                            lane_imm : sat_sum;
    end

    // --------------------------------------------------
    // Horizontal minimum tree, unsigned
    // --------------------------------------------------
    for (genvar j = 0; j < `ALU_LANES/2; j++) begin : gen_min_l1
        logic [`ALU_LANE_W-1:0] lo, hi;

        assign lo        = operand_a_i[(2*j)*`ALU_LANE_W +: `ALU_LANE_W];
        assign hi        = operand_a_i[(2*j+1)*`ALU_LANE_W +: `ALU_LANE_W];
        assign min_l1[j] = (lo > hi) ? hi : lo;
    end

    for (genvar k = 0; k < `ALU_LANES/4; k++) begin : gen_min_l2
        assign min_l2[k] = (min_l1[2*k] > min_l1[2*k+1]) ? min_l1[2*k+1] : min_l1[2*k];
    end

    assign hmin_o = (min_l2[0] > min_l2[1]) ? min_l2[1] : min_l2[0];

endmodule

/* src/alu_result.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_result import alu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   valid_i,
    input  res_sel_e               res_sel_i,
    input  logic [`ALU_XLEN-1:0]   operand_a_i,
    input  logic [`ALU_XLEN-1:0]   operand_b_i,
    input  logic [`ALU_XLEN-1:0]   sum_i,
    input  logic [`ALU_XLEN-1:0]   shift64_i,
    input  logic [`ALU_XLEN-1:0]   addsat_i,
    input  logic [`ALU_XLEN-1:0]   subsat_i,
    input  logic [`ALU_XLEN-1:0]   addsatmin_i,
    input  logic [`ALU_WORD-1:0]   shift32_i,
    input  logic [`ALU_LANE_W-1:0] hmin_i,
    input  logic                   less_i,
    input  logic                   branch_res_i,
    output logic                   valid_o,
    output logic [`ALU_XLEN-1:0]   result_o,
    output logic                   branch_res_o
);

    logic [`ALU_XLEN-1:0]   result_d;
    logic [`ALU_LANE_W-1:0] hmin_final;

    // Tree minimum also competes with the low byte of b
    assign hmin_final = (hmin_i > operand_b_i[`ALU_LANE_W-1:0]) ?
                        operand_b_i[`ALU_LANE_W-1:0] : hmin_i;

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        case (res_sel_i)
            RES_ADDER:   result_d = sum_i;
            RES_ADDER_W: result_d = {{(`ALU_XLEN-`ALU_WORD){sum_i[`ALU_WORD-1]}},
                                     sum_i[`ALU_WORD-1:0]};
            RES_AND:     result_d = operand_a_i & operand_b_i;
            RES_OR:      result_d = operand_a_i | operand_b_i;
            RES_XOR:     result_d = operand_a_i ^ operand_b_i;
            RES_SHIFT:   result_d = shift64_i;
            RES_SHIFT_W: result_d = {{(`ALU_XLEN-`ALU_WORD){shift32_i[`ALU_WORD-1]}}, shift32_i};
            RES_SLT:     result_d = {{(`ALU_XLEN-1){1'b0}}, less_i};
            RES_SIMD_ADDSAT:    result_d = addsat_i;
            RES_SIMD_SUBSAT:    result_d = subsat_i;
            RES_SIMD_ADDSATMIN: result_d = addsatmin_i;
            RES_SIMD_HMIN: result_d = {{(`ALU_XLEN-`ALU_LANE_W){1'b0}}, hmin_final};
            default:     result_d = '0;
        endcase
    end

    // Output stage, holds its value while idle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o      <= 1'b0;
            result_o     <= '0;
            branch_res_o <= 1'b1;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o     <= result_d;
                branch_res_o <= branch_res_i;
            end
        end
    end

endmodule

/* src/alu_shifter.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_shifter (
    input  logic [`ALU_XLEN-1:0] operand_a_i,
    input  logic [`ALU_XLEN-1:0] operand_b_i,
    input  logic                 shift_left_i,
    input  logic                 shift_arith_i,
    output logic [`ALU_XLEN-1:0] shift64_o,
    output logic [`ALU_WORD-1:0] shift32_o
);

    logic [`ALU_XLEN-1:0] op_a_rev;
    logic [`ALU_WORD-1:0] op_a_rev32;
    logic [`ALU_XLEN-1:0] shift_in64;
    logic [`ALU_WORD-1:0] shift_in32;
    logic [`ALU_XLEN:0]   shift_ext64;
    logic [`ALU_WORD:0]   shift_ext32;
    logic [`ALU_XLEN:0]   right64;
    logic [`ALU_WORD:0]   right32;
    logic [`ALU_XLEN-1:0] right64_rev;
    logic [`ALU_WORD-1:0] right32_rev;

    // Left shifts reuse the right shifter on reversed data
    assign op_a_rev   = {<<{operand_a_i}};
    assign op_a_rev32 = {<<{operand_a_i[`ALU_WORD-1:0]}};

    assign shift_in64 = shift_left_i ? op_a_rev : operand_a_i;
    assign shift_in32 = shift_left_i ? op_a_rev32 : operand_a_i[`ALU_WORD-1:0];

    // Extra top bit is the fill value, zero unless arithmetic
    assign shift_ext64 = {shift_arith_i & shift_in64[`ALU_XLEN-1], shift_in64};
    assign shift_ext32 = {shift_arith_i & shift_in32[`ALU_WORD-1], shift_in32};

    // --------------------------------------------------
    // Right shift
    // --------------------------------------------------

    assign right64 = $unsigned($signed(shift_ext64) >>>
                               operand_b_i[$clog2(`ALU_XLEN)-1:0]);
    assign right32 = $unsigned($signed(shift_ext32) >>>
                               operand_b_i[$clog2(`ALU_WORD)-1:0]);

    // Undo the reversal for left shifts
    assign right64_rev = {<<{right64[`ALU_XLEN-1:0]}};
    assign right32_rev = {<<{right32[`ALU_WORD-1:0]}};

    assign shift64_o = shift_left_i ? right64_rev : right64[`ALU_XLEN-1:0];
    assign shift32_o = shift_left_i ? right32_rev : right32[`ALU_WORD-1:0];

endmodule

/* src/alu_top.sv */
`timescale 1ns/1ps
`include "alu_config.svh"

module alu_top import alu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  alu_op_e              op_i,
    input  logic [`ALU_XLEN-1:0] operand_a_i,
    input  logic [`ALU_XLEN-1:0] operand_b_i,
    input  logic [`ALU_XLEN-1:0] imm_i,
    output logic                 valid_o,
    output logic [`ALU_XLEN-1:0] result_o,
    output logic                 branch_res_o
);

    logic                   negate_b, signed_cmp, shift_left, shift_arith;
    res_sel_e               res_sel;
    br_sel_e                br_sel;
    logic [`ALU_XLEN-1:0]   sum, shift64, addsat, subsat, addsatmin;
    logic [`ALU_WORD-1:0]   shift32;
    logic [`ALU_LANE_W-1:0] hmin;
    logic                   less, branch_res;

    alu_decode u_decode (
        .op_i(op_i), .negate_b_o(negate_b), .signed_cmp_o(signed_cmp),
        .shift_left_o(shift_left), .shift_arith_o(shift_arith),
        .res_sel_o(res_sel), .br_sel_o(br_sel)
    );

    // --------------------------------------------------
    // Execute units
    // --------------------------------------------------
    alu_adder u_adder (
        .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .negate_b_i(negate_b),
        .signed_cmp_i(signed_cmp), .br_sel_i(br_sel),
        .sum_o(sum), .less_o(less), .branch_res_o(branch_res)
    );

    alu_shifter u_shifter (
        .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .shift_left_i(shift_left),
        .shift_arith_i(shift_arith), .shift64_o(shift64), .shift32_o(shift32)
    );

    alu_polar_simd u_simd (
        .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .imm_i(imm_i),
        .addsat_o(addsat), .subsat_o(subsat), .addsatmin_o(addsatmin), .hmin_o(hmin)
    );

    alu_result u_result (
        .clk_i(clk_i), .rst_i(rst_i), .valid_i(valid_i), .res_sel_i(res_sel),
        .operand_a_i(operand_a_i), .operand_b_i(operand_b_i), .sum_i(sum),
        .shift64_i(shift64), .addsat_i(addsat), .subsat_i(subsat),
        .addsatmin_i(addsatmin), .shift32_i(shift32), .hmin_i(hmin), .less_i(less),
        .branch_res_i(branch_res), .valid_o(valid_o), .result_o(result_o),
        .branch_res_o(branch_res_o)
    );

endmodule
